/* rtl/isaPkg.sv */
package isaPkg;

    localparam int InstWidth    = 32;
    localparam int AddrWidth    = 32;
    localparam int RegNameWidth = 5;
    localparam int ImmWidth     = 32;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OPIMM  = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcodeE;

    // Internal operation codes handed to the back end
    typedef enum logic [5:0] {
        NOP,
        LUI,
        AUIPC,
        JAL,
        JALR,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW,
        ADDI,
        SLTI,
        SLTIU,
        XORI,
        ORI,
        ANDI,
        SLLI,
        SRLI,
        SRAI,
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } opE;

endpackage

/* rtl/pipePkg.sv */
package pipePkg;

    import isaPkg::*;

    // One word as it comes out of fetch
    typedef struct packed {
        logic [InstWidth-1:0] inst;
        logic [AddrWidth-1:0] pc;
        logic                 pd;     // Predicted taken by the branch predictor
    } fetchEntryT;

    // Decoded instruction bundle sent towards the register file and ROB
    typedef struct packed {
        opE                      op;
        logic [RegNameWidth-1:0] rs1;
        logic [RegNameWidth-1:0] rs2;
        logic [RegNameWidth-1:0] rd;
        logic [ImmWidth-1:0]     imm;
        logic [AddrWidth-1:0]    pc;
        logic                    pd;
    } decodedInstT;

endpackage

/* rtl/instQueue.sv */
module instQueue import pipePkg::*; #(
    parameter int QueueDepth = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       rdy,
    input  logic       fetchEn,
    input  fetchEntryT fetchEntry,
    input  logic       popEn,
    output logic       queueValid,
    output logic       queueFull,
    output fetchEntryT queueHead
);

    localparam int PtrWidth   = $clog2(QueueDepth);
    localparam int CountWidth = $clog2(QueueDepth + 1);

    fetchEntryT            entries [QueueDepth];
    logic [PtrWidth-1:0]   rdPtr;
    logic [PtrWidth-1:0]   wrPtr;
    logic [CountWidth-1:0] count;
    logic                  push;

    assign queueValid = (count != '0);
    assign queueFull  = (count == CountWidth'(QueueDepth));
    assign queueHead  = entries[rdPtr];

    // A full queue still takes a word when the head leaves on the same edge
    assign push = rdy && fetchEn && (!queueFull || popEn);

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= fetchEntry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;          // Wraps since the depth is a power of two
            end
            if (popEn) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({push, popEn})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* rtl/instDecoder.sv */
module instDecoder import isaPkg::*, pipePkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        rdy,
    input  logic        queueValid,
    input  fetchEntryT  queueHead,
    input  logic        robFull,
    output logic        popEn,
    output logic        decValid,
    output decodedInstT decInst
);

    logic [InstWidth-1:0] inst;
    opcodeE               opcode;
    logic [2:0]           funct3;
    logic [3:0]           funct;
    decodedInstT          decNext;
    logic                 advance;

    assign inst   = queueHead.inst;
    assign opcode = opcodeE'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct  = {inst[30], inst[14:12]};

    always_comb begin
        decNext.rs1 = inst[19:15];
        decNext.rs2 = inst[24:20];
        decNext.rd  = inst[11:7];
        decNext.pc  = queueHead.pc;
        decNext.pd  = queueHead.pd;

        case (opcode)
            OPC_LUI, OPC_AUIPC: decNext.imm = {inst[31:12], 12'b0};
            OPC_JAL:    decNext.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            OPC_BRANCH: decNext.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            OPC_JALR, OPC_OPIMM, OPC_LOAD: decNext.imm = {{21{inst[31]}}, inst[30:20]};
            OPC_STORE:  decNext.imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
            default:    decNext.imm = '0;       // R-type and unknown opcodes
        endcase

        decNext.op = NOP;
        case (opcode)
            OPC_LUI:   decNext.op = LUI;
            OPC_AUIPC: decNext.op = AUIPC;
            OPC_JAL:   decNext.op = JAL;
            OPC_JALR:  decNext.op = JALR;
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  decNext.op = BEQ;
                    3'b001:  decNext.op = BNE;
                    3'b100:  decNext.op = BLT;
                    3'b101:  decNext.op = BGE;
                    3'b110:  decNext.op = BLTU;
                    3'b111:  decNext.op = BGEU;
                    default: decNext.op = NOP;
                endcase
            end
            OPC_LOAD: begin
                case (funct3)
                    3'b000:  decNext.op = LB;
                    3'b001:  decNext.op = LH;
                    3'b010:  decNext.op = LW;
                    3'b100:  decNext.op = LBU;
                    3'b101:  decNext.op = LHU;
                    default: decNext.op = NOP;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    3'b000:  decNext.op = SB;
                    3'b001:  decNext.op = SH;
                    3'b010:  decNext.op = SW;
                    default: decNext.op = NOP;
                endcase
            end
            OPC_OPIMM: begin
                // Bit 30 only matters for the shifts, the rest ignore it
                case (funct)
                    4'b0000, 4'b1000: decNext.op = ADDI;
                    4'b0010, 4'b1010: decNext.op = SLTI;
                    4'b0011, 4'b1011: decNext.op = SLTIU;
                    4'b0100, 4'b1100: decNext.op = XORI;
                    4'b0110, 4'b1110: decNext.op = ORI;
                    4'b0111, 4'b1111: decNext.op = ANDI;
                    4'b0001:          decNext.op = SLLI;
                    4'b0101:          decNext.op = SRLI;
                    4'b1101:          decNext.op = SRAI;
                    default:          decNext.op = NOP;
                endcase
            end
            OPC_OP: begin
                case (funct)
                    4'b0000: decNext.op = ADD;
                    4'b1000: decNext.op = SUB;
                    4'b0001: decNext.op = SLL;
                    4'b0010: decNext.op = SLT;
                    4'b0011: decNext.op = SLTU;
                    4'b0100: decNext.op = XOR;
                    4'b0101: decNext.op = SRL;
                    4'b1101: decNext.op = SRA;
                    4'b0110: decNext.op = OR;
                    4'b0111: decNext.op = AND;
                    default: decNext.op = NOP;
                endcase
            end
            default: decNext.op = NOP;
        endcase
    end

    // The stage register moves on unless its content is stuck behind a full ROB
    assign advance = rdy && (!decValid || !robFull);
    assign popEn   = advance && queueValid;

    always_ff @(posedge clk) begin
        if (rst) begin
            decValid <= 1'b0;
        end else if (advance) begin
            decValid <= queueValid;
        end
    end

    always_ff @(posedge clk) begin
        if (popEn) begin
            decInst <= decNext;
        end
    end

endmodule

/* rtl/robAllocator.sv */
module robAllocator import pipePkg::*; #(
    parameter int RobSize = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       rdy,
    input  logic                       decValid,
    input  logic                       commitEn,
    input  decodedInstT                decInst,
    output logic                       robFull,
    output logic                       dispatchEn,
    output decodedInstT                dispatchInst,
    output logic [$clog2(RobSize)-1:0] robTag
);

    localparam int TagWidth = $clog2(RobSize);
    localparam int OccWidth = $clog2(RobSize + 1);

    logic [TagWidth-1:0] nextTag;
    logic [OccWidth-1:0] occupancy;
    logic                accept;
    logic                dispatchReg;

    assign robFull = (occupancy == OccWidth'(RobSize));
    assign accept  = decValid && !robFull && rdy;

    // A pending pulse is held through a stall and shows once rdy returns
    assign dispatchEn = dispatchReg && rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            dispatchReg <= 1'b0;
            nextTag     <= '0;
            robTag      <= '0;
            occupancy   <= '0;
        end else begin
            if (rdy) begin
                dispatchReg <= accept;
            end
            if (accept) begin
                robTag  <= nextTag;
                nextTag <= nextTag + 1'b1;      // Wraps at RobSize
            end
            case ({accept, commitEn && rdy})    // Occupancy is frozen along with the rest
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dispatchInst <= decInst;
        end
    end

endmodule

/* rtl/frontEnd.sv */
module frontEnd import pipePkg::*; #(
    parameter int QueueDepth = 4,
    parameter int RobSize    = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       rdy,
    input  logic                       fetchEn,
    input  fetchEntryT                 fetchEntry,
    input  logic                       commitEn,
    output logic                       queueFull,
    output logic                       dispatchEn,
    output decodedInstT                dispatchInst,
    output logic [$clog2(RobSize)-1:0] robTag
);

    logic        queueValid;
    fetchEntryT  queueHead;
    logic        popEn;
    logic        decValid;
    decodedInstT decInst;
    logic        robFull;

    instQueue #(
        .QueueDepth(QueueDepth)
    ) instQueue_i (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .fetchEn   (fetchEn),
        .fetchEntry(fetchEntry),
        .popEn     (popEn),
        .queueValid(queueValid),
        .queueFull (queueFull),
        .queueHead (queueHead)
    );

    instDecoder instDecoder_i (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .queueValid(queueValid),
        .queueHead (queueHead),
        .robFull   (robFull),
        .popEn     (popEn),
        .decValid  (decValid),
        .decInst   (decInst)
    );

    robAllocator #(
        .RobSize(RobSize)
    ) robAllocator_i (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .decValid    (decValid),
        .commitEn    (commitEn),
        .decInst     (decInst),
        .robFull     (robFull),
        .dispatchEn  (dispatchEn),
        .dispatchInst(dispatchInst),
        .robTag      (robTag)
    );

endmodule

/* testbench/frontEnd_sva.sv */
module frontEndSva #(
    parameter int RobSize = 8
) (
    input logic                         clk,
    input logic                         rst,
    input logic                         rdy,
    input logic                         commitEn,
    input logic                         robFull,
    input logic                         dispatchEn,
    input logic [$clog2(RobSize)-1:0]   robTag,
    input logic [$clog2(RobSize+1)-1:0] occupancy
);

    occNoOverflow: assert property (@(posedge clk) disable iff (rst) occupancy <= RobSize)
        else $error("ROB occupancy above its size");

    // A pulse held through a stall may show up late, so only a fresh accept counts
    noDispatchWhenFull: assert property (@(posedge clk) disable iff (rst)
        $rose(dispatchEn) && $past(rdy) |-> !$past(robFull))
        else $error("Dispatch started while the ROB was full");

    // A low rdy gives no pulse and leaves tag and occupancy where they were
    quietWhenNotReady: assert property (@(posedge clk) disable iff (rst)
        !rdy |=> !$past(dispatchEn) && $stable(occupancy) && $stable(robTag))
        else $error("Allocator dispatched or moved while rdy is low");

    noCommitWhenEmpty: assert property (@(posedge clk) disable iff (rst)
        commitEn |-> occupancy != '0)
        else $error("Commit with no outstanding tag");

endmodule

bind robAllocator frontEndSva #(
    .RobSize(RobSize)
) frontEndSva_i (
    .clk       (clk),
    .rst       (rst),
    .rdy       (rdy),
    .commitEn  (commitEn),
    .robFull   (robFull),
    .dispatchEn(dispatchEn),
    .robTag    (robTag),
    .occupancy (occupancy)
);

/* testbench/frontEndTb.sv */
module frontEndTb import isaPkg::*, pipePkg::*; ();

    localparam int QueueDepth    = 4;
    localparam int RobSize       = 8;
    localparam int NumInst       = 400;
    localparam int TimeoutCycles = NumInst * 20;

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       rdy;
    logic                       fetchEn;
    fetchEntryT                 fetchEntry;
    logic                       commitEn;
    logic                       queueFull;
    logic                       dispatchEn;
    decodedInstT                dispatchInst;
    logic [$clog2(RobSize)-1:0] robTag;

    logic [31:0]   lfsrState = 32'hfd7;
    decodedInstT   expQ [$];
    int            tagQ [$];
    int            sent = 0;
    int            dispatched = 0;
    int            committed = 0;
    int            maxOutstanding = 0;
    int            cycles = 0;
    int            valueErrors = 0;
    int            otherErrors = 0;
    logic          sawQueueFull = 1'b0;
    logic [6:0]    legalOps [9] = '{7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03, 7'h23, 7'h13, 7'h33};

    frontEnd #(
        .QueueDepth(QueueDepth),
        .RobSize   (RobSize)
    ) frontEnd_i (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .fetchEn     (fetchEn),
        .fetchEntry  (fetchEntry),
        .commitEn    (commitEn),
        .queueFull   (queueFull),
        .dispatchEn  (dispatchEn),
        .dispatchInst(dispatchInst),
        .robTag      (robTag)
    );

    always #5 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1, one step per bit handed out
    function automatic logic [31:0] takeBits(int n);
        logic [31:0] result;
        logic        fb;
        result = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            result = {result[30:0], fb};
        end
        return result;
    endfunction

    function automatic fetchEntryT makeEntry();
        fetchEntryT e;
        e.inst = takeBits(32);
        e.pc   = takeBits(32) & 32'hffff_fffc;
        e.pd   = (takeBits(1) != 0);
        if (takeBits(3) == 0) begin
            if (takeBits(1) != 0) begin
                e.inst[6:0] = (takeBits(1) != 0) ? 7'h0f : 7'h73;   // FENCE or SYSTEM
            end else begin
                e.inst[6:0]   = 7'h33;      // SLL with bit 30 set has no meaning
                e.inst[14:12] = 3'b001;
                e.inst[30]    = 1'b1;
            end
        end else begin
            e.inst[6:0] = legalOps[takeBits(4) % 9];
            case (e.inst[6:0])
                7'h33: begin
                    if (e.inst[14:12] != 3'b000 && e.inst[14:12] != 3'b101)
                        e.inst[30] = 1'b0;
                end
                7'h13: if (e.inst[14:12] == 3'b001) e.inst[30] = 1'b0;
                7'h23: begin
                    e.inst[14] = 1'b0;
                    if (e.inst[13:12] == 2'b11) e.inst[13] = 1'b0;
                end
                7'h03: if (e.inst[14:12] == 3'b011 || e.inst[14:13] == 2'b11) e.inst[13] = 1'b0;
                7'h63: if (e.inst[14:13] == 2'b01) e.inst[14] = 1'b1;
                default: ;
            endcase
        end
        return e;
    endfunction

    // Reference decode straight from the RV32I encoding tables
    function automatic decodedInstT refDecode(fetchEntryT f);
        logic [31:0] i;
        logic [2:0]  f3;
        logic        b30;
        decodedInstT d;
        i   = f.inst;
        f3  = i[14:12];
        b30 = i[30];
        d.rs1 = i[19:15];
        d.rs2 = i[24:20];
        d.rd  = i[11:7];
        d.pc  = f.pc;
        d.pd  = f.pd;
        d.imm = '0;
        d.op  = NOP;
        case (i[6:0])
            7'h37: begin
                d.op  = LUI;
                d.imm = {i[31:12], 12'h000};
            end
            7'h17: begin
                d.op  = AUIPC;
                d.imm = {i[31:12], 12'h000};
            end
            7'h6f: begin
                d.op  = JAL;
                d.imm = 32'($signed({i[31], i[19:12], i[20], i[30:21], 1'b0}));
            end
            7'h67: begin
                d.op  = JALR;
                d.imm = 32'($signed(i[31:20]));
            end
            7'h63: begin
                d.imm = 32'($signed({i[31], i[7], i[30:25], i[11:8], 1'b0}));
                case (f3)
                    3'd0: d.op = BEQ;
                    3'd1: d.op = BNE;
                    3'd4: d.op = BLT;
                    3'd5: d.op = BGE;
                    3'd6: d.op = BLTU;
                    3'd7: d.op = BGEU;
                    default: d.op = NOP;
                endcase
            end
            7'h03: begin
                d.imm = 32'($signed(i[31:20]));
                case (f3)
                    3'd0: d.op = LB;
                    3'd1: d.op = LH;
                    3'd2: d.op = LW;
                    3'd4: d.op = LBU;
                    3'd5: d.op = LHU;
                    default: d.op = NOP;
                endcase
            end
            7'h23: begin
                d.imm = 32'($signed({i[31:25], i[11:7]}));
                d.op  = (f3 == 3'd0) ? SB : (f3 == 3'd1) ? SH : (f3 == 3'd2) ? SW : NOP;
            end
            7'h13: begin
                d.imm = 32'($signed(i[31:20]));
                case (f3)
                    3'd0: d.op = ADDI;
                    3'd1: d.op = b30 ? NOP : SLLI;
                    3'd2: d.op = SLTI;
                    3'd3: d.op = SLTIU;
                    3'd4: d.op = XORI;
                    3'd5: d.op = b30 ? SRAI : SRLI;
                    3'd6: d.op = ORI;
                    default: d.op = ANDI;
                endcase
            end
            7'h33: begin
                case (f3)
                    3'd0: d.op = b30 ? SUB : ADD;
                    3'd1: d.op = SLL;
                    3'd2: d.op = SLT;
                    3'd3: d.op = SLTU;
                    3'd4: d.op = XOR;
                    3'd5: d.op = b30 ? SRA : SRL;
                    3'd6: d.op = OR;
                    default: d.op = AND;
                endcase
                if (b30 && f3 != 3'd0 && f3 != 3'd5) d.op = NOP;
            end
            default: ;
        endcase
        return d;
    endfunction

    task automatic checkField(string name, logic [31:0] got, logic [31:0] want);
        assert (got == want) else begin
            valueErrors++;
            $display("FAILED at time %0t: %s is %0h, expected %0h", $time, name, got, want);
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TimeoutCycles) begin
            otherErrors++;
            $display("Timeout: dispatch stalled after %0d of %0d instructions", dispatched, NumInst);
            $display("Checks done: %0d value errors, %0d other errors", valueErrors, otherErrors);
            $display("TEST FAIL");
            $finish;
        end
    end

    // Outputs are read mid-cycle, well away from the driving edge
    always @(negedge clk) begin
        decodedInstT want;
        int          wantTag;
        if (!rst) begin
            if (queueFull) sawQueueFull = 1'b1;
            if (dispatchEn) begin
                assert (expQ.size() > 0) else begin
                    otherErrors++;
                    $display("Dispatch at time %0t with no instruction waiting in the model", $time);
                end
                if (expQ.size() > 0) begin
                    want    = expQ.pop_front();
                    wantTag = tagQ.pop_front();
                    checkField("op", 32'(dispatchInst.op), 32'(want.op));
                    checkField("rs1", 32'(dispatchInst.rs1), 32'(want.rs1));
                    checkField("rs2", 32'(dispatchInst.rs2), 32'(want.rs2));
                    checkField("rd", 32'(dispatchInst.rd), 32'(want.rd));
                    checkField("imm", dispatchInst.imm, want.imm);
                    checkField("pc", dispatchInst.pc, want.pc);
                    checkField("pd", 32'(dispatchInst.pd), 32'(want.pd));
                    checkField("robTag", 32'(robTag), 32'(wantTag));
                end
                dispatched++;
            end
            if (dispatched - committed > maxOutstanding) maxOutstanding = dispatched - committed;
        end
    end

    initial begin
        rst        = 1'b1;
        rdy        = 1'b0;
        fetchEn    = 1'b0;
        fetchEntry = '0;
        commitEn   = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        while (dispatched < NumInst) begin
            @(posedge clk);
            #1;
            rdy      = (takeBits(3) != 0);
            fetchEn  = 1'b0;
            commitEn = 1'b0;
            if (rdy && !queueFull && sent < NumInst && takeBits(2) != 0) begin
                fetchEn    = 1'b1;
                fetchEntry = makeEntry();
                expQ.push_back(refDecode(fetchEntry));
                tagQ.push_back(sent % RobSize);
                sent++;
            end
            // Every fourth stretch of 32 cycles holds commits back so the ROB fills
            if (rdy && cycles[6:5] != 2'b11 && dispatched > committed && takeBits(1) != 0) begin
                commitEn = 1'b1;
                committed++;
            end
        end
        @(posedge clk);
        #1;
        fetchEn  = 1'b0;
        commitEn = 1'b0;
        repeat (4) @(posedge clk);
        assert (sawQueueFull && maxOutstanding == RobSize) else begin
            otherErrors++;
            $display("The ROB never filled up or the queue never reported full");
        end
        $display("Checks done: %0d value errors, %0d other errors", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* build.f */
rtl/isaPkg.sv
rtl/pipePkg.sv
rtl/instQueue.sv
rtl/instDecoder.sv
rtl/robAllocator.sv
rtl/frontEnd.sv
testbench/frontEnd_sva.sv
testbench/frontEndTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= frontEndTb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
